/* Bender.yml */
package:
  name: qsim

sources:
  - verilog/qsim_pkg.sv
  - verilog/qsim_ctrl.sv
  - verilog/qsim_mem_seq.sv
  - verilog/qsim_cmac.sv
  - verilog/qsim_top.sv
  - target: test
    files:
      - testbench/tb_clk_gen.sv
      - testbench/tb_sram.sv
      - testbench/tb_qsim.sv

/* tb.f */
verilog/qsim_pkg.sv
verilog/qsim_ctrl.sv
verilog/qsim_mem_seq.sv
verilog/qsim_cmac.sv
verilog/qsim_top.sv
testbench/tb_clk_gen.sv
testbench/tb_sram.sv
testbench/tb_qsim.sv

/* testbench/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic reset_n
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Reset held low for 16 cycles
  initial begin
    reset_n = 1'b0;
    repeat (16) @(posedge clk);
    reset_n <= 1'b1;
  end

endmodule

/* testbench/tb_qsim.sv */
`timescale 1ns/1ps

module tb_qsim;

  // 12 cycles per M*N*N + N of the three runs, plus margin
  localparam int TIMEOUT_CYCLES = 12 * ((1 * 4 + 2) + (3 * 16 + 4) + (2 * 64 + 8)) + 2000;

  logic clk;
  logic reset_n;
  logic dut_valid;
  logic dut_ready;

  qsim_pkg::state_addr_t in_addr;
  qsim_pkg::gate_addr_t  gate_addr;
  qsim_pkg::gate_addr_t  scr_addr;
  qsim_pkg::cplx_t       in_data;
  qsim_pkg::cplx_t       gate_data;
  qsim_pkg::cplx_t       scr_data;
  qsim_pkg::state_wr_t   out_wr;
  qsim_pkg::scratch_wr_t scr_wr;

  // Reference model vector and current gate matrix
  logic signed [31:0] vec_re [0:15];
  logic signed [31:0] vec_im [0:15];
  logic signed [31:0] mat_re [0:255];
  logic signed [31:0] mat_im [0:255];

  int          exp_n;
  int          out_cnt;
  int          scr_cnt;
  logic [31:0] out_seen;
  logic        ready_q;
  int          cycles;
  int          value_errors;
  int          fault_errors;
  int          seed_val;

  tb_clk_gen clk_gen_i (
    .clk     (clk),
    .reset_n (reset_n)
  );

  tb_sram #(.ADDR_W(qsim_pkg::STATE_ADDR_W)) in_mem_i (
    .clk(clk), .rd_addr(in_addr), .rd_data(in_data),
    .wr_en(1'b0), .wr_addr('0), .wr_data('0)
  );
  tb_sram #(.ADDR_W(qsim_pkg::GATE_ADDR_W)) gate_mem_i (
    .clk(clk), .rd_addr(gate_addr), .rd_data(gate_data),
    .wr_en(1'b0), .wr_addr('0), .wr_data('0)
  );
  tb_sram #(.ADDR_W(qsim_pkg::GATE_ADDR_W)) scr_mem_i (
    .clk(clk), .rd_addr(scr_addr), .rd_data(scr_data),
    .wr_en(scr_wr.en), .wr_addr(scr_wr.addr), .wr_data(scr_wr.data)
  );
  tb_sram #(.ADDR_W(qsim_pkg::STATE_ADDR_W)) out_mem_i (
    .clk(clk), .rd_addr('0), .rd_data(),
    .wr_en(out_wr.en), .wr_addr(out_wr.addr), .wr_data(out_wr.data)
  );

  qsim_top dut_i (
    .clk                             (clk),
    .reset_n                         (reset_n),
    .dut_valid                       (dut_valid),
    .dut_ready                       (dut_ready),
    .q_state_input_sram_read_address (in_addr),
    .q_state_input_sram_read_data    (in_data),
    .q_gates_sram_read_address       (gate_addr),
    .q_gates_sram_read_data          (gate_data),
    .scratchpad_sram_read_address    (scr_addr),
    .scratchpad_sram_read_data       (scr_data),
    .q_state_output_sram_wr          (out_wr),
    .scratchpad_sram_wr              (scr_wr)
  );

  task automatic report_mismatch(input string name, input logic [63:0] exp_val,
                                 input logic [63:0] act_val);
    value_errors++;
    $display("FAILED at %0t: %s expected %h, got %h", $time, name, exp_val, act_val);
  endtask

  task automatic report_fault(input string msg);
    fault_errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  // --------------------
  // Reference model
  // --------------------
  // Full signed product, arithmetic shift, wrapped to 32 bits
  function automatic logic signed [31:0] fixed_mul(input logic signed [31:0] a,
                                                   input logic signed [31:0] b);
    logic signed [63:0] p;
    p = a * b;
    return p[qsim_pkg::FRAC_BITS +: 32];
  endfunction

  // Within +-4.0, negative on request
  function automatic logic signed [31:0] rand_fixed(input bit neg);
    logic signed [31:0] mag;
    mag = $urandom_range(4 << qsim_pkg::FRAC_BITS, 1);
    if (neg || $urandom_range(1, 0) == 1) begin
      return -mag;
    end
    return mag;
  endfunction

  task automatic apply_gate(input int n);
    logic signed [31:0] nxt_re [0:15];
    logic signed [31:0] nxt_im [0:15];
    int i;
    int k;
    for (i = 0; i < n; i++) begin
      nxt_re[i] = 0;
      nxt_im[i] = 0;
      for (k = 0; k < n; k++) begin
        nxt_re[i] = nxt_re[i] + fixed_mul(mat_re[i*n+k], vec_re[k])
                              - fixed_mul(mat_im[i*n+k], vec_im[k]);
        nxt_im[i] = nxt_im[i] + fixed_mul(mat_re[i*n+k], vec_im[k])
                              + fixed_mul(mat_im[i*n+k], vec_re[k]);
      end
    end
    for (i = 0; i < n; i++) begin
      vec_re[i] = nxt_re[i];
      vec_im[i] = nxt_im[i];
    end
  endtask

  // Fill input and gate SRAMs and run the model over all gates
  task automatic load_run(input int q, input int m, input bit neg);
    int n;
    int i;
    int g;
    n = 1 << q;
    in_mem_i.mem[0] <= {32'(q), 32'(m)};
    for (i = 0; i < n; i++) begin
      vec_re[i] = rand_fixed(1'b0);
      vec_im[i] = rand_fixed(1'b0);
      in_mem_i.mem[i+1] <= {vec_re[i], vec_im[i]};
    end
    for (g = 0; g < m; g++) begin
      for (i = 0; i < n * n; i++) begin
        mat_re[i] = rand_fixed(neg);
        mat_im[i] = rand_fixed(neg);
        gate_mem_i.mem[g*n*n + i] <= {mat_re[i], mat_im[i]};
      end
      apply_gate(n);
    end
  endtask

  task automatic check_output(input int n, input int m);
    int i;
    for (i = 0; i < n; i++) begin
      assert (out_mem_i.mem[i] == {vec_re[i], vec_im[i]})
        else report_mismatch($sformatf("output word %0d", i), {vec_re[i], vec_im[i]},
                             out_mem_i.mem[i]);
    end
    assert (out_cnt == n) else report_mismatch("output write count", n, out_cnt);
    assert (scr_cnt == (m - 1) * n)
      else report_mismatch("scratchpad write count", (m - 1) * n, scr_cnt);
  endtask

  task automatic wait_ready();
    while (!dut_ready) begin
      @(posedge clk);
    end
  endtask

  // --------------------
  // Run sequence
  // --------------------
  task automatic do_run(input int q, input int m, input bit neg, input bit poke);
    wait_ready();
    load_run(q, m, neg);
    exp_n     <= 1 << q;
    dut_valid <= 1'b1;
    @(posedge clk);
    dut_valid <= 1'b0;
    if (poke) begin
      // Start request once the first gate is written back
      @(posedge clk);
      while (scr_cnt < (1 << q)) begin
        @(posedge clk);
      end
      assert (!dut_ready) else report_fault("dut_ready is high in the middle of a run");
      dut_valid <= 1'b1;
      @(posedge clk);
      dut_valid <= 1'b0;
    end
    @(posedge clk);
    wait_ready();
    check_output(1 << q, m);
  endtask

  // Write port and dut_ready checks on every edge
  always @(posedge clk) begin
    if (reset_n) begin
      assert (!dut_ready || (!out_wr.en && !scr_wr.en))
        else report_fault("A write enable is high while dut_ready is high");
      if (dut_valid && dut_ready) begin
        out_cnt  <= 0;
        scr_cnt  <= 0;
        out_seen <= '0;
      end
      if (out_wr.en) begin
        assert (out_wr.addr < exp_n && !out_seen[out_wr.addr])
          else report_fault($sformatf("Output address %0d is out of range or written twice",
                                      out_wr.addr));
        out_seen[out_wr.addr] <= 1'b1;
        out_cnt               <= out_cnt + 1;
      end
      if (scr_wr.en) begin
        assert (out_cnt == 0) else report_fault("Scratchpad write after output writes began");
        scr_cnt <= scr_cnt + 1;
      end
      if (dut_ready && !ready_q) begin
        assert (out_cnt == exp_n) else report_fault("dut_ready rose before the last output write");
      end
      ready_q <= dut_ready;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Run stopped after %0d cycles without finishing", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  initial begin
    seed_val     = $urandom(32'he9ea_f230);
    dut_valid    = 1'b0;
    exp_n        = 0;
    out_cnt      = 0;
    scr_cnt      = 0;
    out_seen     = '0;
    ready_q      = 1'b1;
    cycles       = 0;
    value_errors = 0;
    fault_errors = 0;
    @(posedge reset_n);
    repeat (4) @(posedge clk);
    assert (dut_ready) else report_fault("dut_ready is low after reset");
    do_run(1, 1, 1'b0, 1'b0);
    do_run(2, 3, 1'b0, 1'b1);
    // Back to back, negative gate elements
    do_run(3, 2, 1'b1, 1'b0);
    $display("Summary: %0d value errors, %0d protocol errors", value_errors, fault_errors);
    if (value_errors + fault_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* testbench/tb_sram.sv */
`timescale 1ns/1ps

module tb_sram #(
  parameter int ADDR_W = 5
) (
  input  logic              clk,
  input  logic [ADDR_W-1:0] rd_addr,
  output qsim_pkg::cplx_t   rd_data,
  input  logic              wr_en,
  input  logic [ADDR_W-1:0] wr_addr,
  input  qsim_pkg::cplx_t   wr_data
);

  qsim_pkg::cplx_t mem [0:(1 << ADDR_W) - 1];

  // Address-derived fill so unwritten words stand out
  initial begin
    int a;
    for (a = 0; a < (1 << ADDR_W); a++) begin
      mem[a] = {32'(a) ^ 32'h5a5a_0000, ~32'(a)};
    end
    rd_data = '0;
  end

  // Read data one cycle after the address, old data on a collision
  always @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    rd_data <= mem[rd_addr];
  end

endmodule

/* verilog/qsim_cmac.sv */
`timescale 1ns/1ps

module qsim_cmac (
  input  logic              clk,
  input  logic              reset_n,
  input  qsim_pkg::mac_op_t mac_op,
  input  logic              from_scratch,
  input  qsim_pkg::cplx_t   gate_data,
  input  qsim_pkg::cplx_t   state_data,
  input  qsim_pkg::cplx_t   scratch_data,
  output qsim_pkg::cplx_t   acc
);

  qsim_pkg::cplx_t src;

  logic signed [qsim_pkg::HALF_W-1:0]   op_a;
  logic signed [qsim_pkg::HALF_W-1:0]   op_b;
  logic signed [2*qsim_pkg::HALF_W-1:0] prod_full;
  logic signed [2*qsim_pkg::HALF_W-1:0] prod_shift;

  // Product stage output and the operation it belongs to
  logic signed [qsim_pkg::HALF_W-1:0]   prod_q;
  qsim_pkg::mac_op_t                    pend_op;

  // Input vector for the first gate, scratchpad after that
  assign src = from_scratch ? scratch_data : state_data;

  // --------------------
  // Operand select
  // --------------------
  always_comb begin
    case (mac_op)
      qsim_pkg::MAC_RR: begin
        op_a = gate_data.re;
        op_b = src.re;
      end
      qsim_pkg::MAC_II: begin
        op_a = gate_data.im;
        op_b = src.im;
      end
      qsim_pkg::MAC_RI: begin
        op_a = gate_data.re;
        op_b = src.im;
      end
      qsim_pkg::MAC_IR: begin
        op_a = gate_data.im;
        op_b = src.re;
      end
      default: begin
        op_a = '0;
        op_b = '0;
      end
    endcase
  end

  // Full signed product, truncated back to the fixed-point grid
  assign prod_full  = op_a * op_b;
  assign prod_shift = prod_full >>> qsim_pkg::FRAC_BITS;

  always_ff @(posedge clk) begin
    prod_q <= prod_shift[qsim_pkg::HALF_W-1:0];
  end

  // --------------------
  // Accumulate
  // --------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      pend_op <= qsim_pkg::MAC_IDLE;
      acc     <= '0;
    end else begin
      pend_op <= mac_op;
      if (mac_op == qsim_pkg::MAC_CLEAR) begin
        acc <= '0;
      end else begin
        case (pend_op)
          qsim_pkg::MAC_RR: acc.re <= acc.re + prod_q;
          // i*i term subtracts from the real part
          qsim_pkg::MAC_II: acc.re <= acc.re - prod_q;
          qsim_pkg::MAC_RI,
          qsim_pkg::MAC_IR: acc.im <= acc.im + prod_q;
          default: ;
        endcase
      end
    end
  end

endmodule

/* verilog/qsim_ctrl.sv */
`timescale 1ns/1ps

module qsim_ctrl (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               dut_valid,
  input  qsim_pkg::cplx_t    header,
  output logic               dut_ready,
  output qsim_pkg::mem_cmd_t mem_cmd,
  output qsim_pkg::mac_op_t  mac_op,
  output logic               from_scratch
);

  typedef enum logic [3:0] {
    S_IDLE,
    S_HDR_WAIT,
    S_HDR,
    S_FETCH,
    S_RR,
    S_II,
    S_RI,
    S_IR,
    S_DRAIN,
    S_STORE,
    S_CLEAR,
    S_DONE
  } state_t;

  state_t state;
  state_t next_state;

  // Vector length N and gate count M of the current run
  logic [qsim_pkg::MAX_QUBITS:0]   n_dim;
  logic [qsim_pkg::GCNT_W-1:0]     num_gates;

  logic [qsim_pkg::MAX_QUBITS-1:0] col_cnt;
  logic [qsim_pkg::MAX_QUBITS-1:0] row_cnt;
  logic [qsim_pkg::GCNT_W-1:0]     gate_cnt;

  logic last_col;
  logic last_row;
  logic last_gate;

  assign last_col  = ({1'b0, col_cnt} == n_dim - 1'b1);
  assign last_row  = ({1'b0, row_cnt} == n_dim - 1'b1);
  assign last_gate = (gate_cnt == num_gates - 1'b1);

  assign dut_ready    = (state == S_IDLE) || (state == S_DONE);
  assign from_scratch = (gate_cnt != '0);

  // --------------------
  // State register
  // --------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state <= S_IDLE;
    end else begin
      state <= next_state;
    end
  end

  // Next state and strobes
  always_comb begin
    next_state = state;
    mem_cmd    = '0;
    mac_op     = qsim_pkg::MAC_IDLE;
    case (state)
      S_IDLE: begin
        if (dut_valid) begin
          mem_cmd.load_header = 1'b1;
          next_state          = S_HDR_WAIT;
        end
      end
      S_HDR_WAIT: next_state = S_HDR;
      S_HDR: begin
        mem_cmd.clear = 1'b1;
        mac_op        = qsim_pkg::MAC_CLEAR;
        next_state    = S_FETCH;
      end
      // Wait for the element read to return
      S_FETCH: next_state = S_RR;
      S_RR: begin
        mac_op     = qsim_pkg::MAC_RR;
        next_state = S_II;
      end
      S_II: begin
        mac_op     = qsim_pkg::MAC_II;
        next_state = S_RI;
      end
      S_RI: begin
        mac_op     = qsim_pkg::MAC_RI;
        next_state = S_IR;
      end
      S_IR: begin
        mac_op             = qsim_pkg::MAC_IR;
        mem_cmd.fetch_next = 1'b1;
        if (last_col) begin
          mem_cmd.row_restart = 1'b1;
          next_state          = S_DRAIN;
        end else begin
          next_state = S_FETCH;
        end
      end
      // Last product of the row lands in the accumulator here
      S_DRAIN: next_state = S_STORE;
      S_STORE: begin
        mem_cmd.store_out     = last_gate;
        mem_cmd.store_scratch = !last_gate;
        next_state            = S_CLEAR;
      end
      S_CLEAR: begin
        mac_op = qsim_pkg::MAC_CLEAR;
        if (last_row && last_gate) begin
          next_state = S_DONE;
        end else begin
          mem_cmd.gate_done = last_row;
          next_state        = S_FETCH;
        end
      end
      S_DONE: next_state = S_IDLE;
      default: next_state = S_IDLE;
    endcase
  end

  // --------------------
  // Run counters
  // --------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      n_dim     <= '0;
      num_gates <= '0;
      col_cnt   <= '0;
      row_cnt   <= '0;
      gate_cnt  <= '0;
    end else begin
      case (state)
        S_HDR: begin
          // Upper half holds q, lower half holds M
          n_dim     <= {{qsim_pkg::MAX_QUBITS{1'b0}}, 1'b1} << header.re[qsim_pkg::QCNT_W-1:0];
          num_gates <= header.im[qsim_pkg::GCNT_W-1:0];
          col_cnt   <= '0;
          row_cnt   <= '0;
          gate_cnt  <= '0;
        end
        S_IR: begin
          col_cnt <= last_col ? '0 : col_cnt + 1'b1;
        end
        S_CLEAR: begin
          if (last_row) begin
            row_cnt  <= '0;
            gate_cnt <= gate_cnt + 1'b1;
          end else begin
            row_cnt <= row_cnt + 1'b1;
          end
        end
        default: ;
      endcase
    end
  end

endmodule

/* verilog/qsim_mem_seq.sv */
`timescale 1ns/1ps

module qsim_mem_seq (
  input  logic                  clk,
  input  logic                  reset_n,
  input  qsim_pkg::mem_cmd_t    mem_cmd,
  input  logic                  from_scratch,
  input  qsim_pkg::cplx_t       acc,
  output qsim_pkg::state_addr_t in_rd_addr,
  output qsim_pkg::gate_addr_t  gate_rd_addr,
  output qsim_pkg::gate_addr_t  scratch_rd_addr,
  output qsim_pkg::state_wr_t   out_wr,
  output qsim_pkg::scratch_wr_t scratch_wr
);

  // Start of the source vector in the scratchpad
  qsim_pkg::gate_addr_t  scratch_base;
  // Start of the vector being written to the scratchpad
  qsim_pkg::gate_addr_t  scratch_wr_base;
  qsim_pkg::gate_addr_t  scratch_wr_addr;
  qsim_pkg::state_addr_t out_wr_addr;

  // --------------------
  // Read side
  // --------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      in_rd_addr      <= '0;
      gate_rd_addr    <= '0;
      scratch_base    <= '0;
      scratch_rd_addr <= '0;
    end else if (mem_cmd.clear) begin
      // State vector starts after the header word
      in_rd_addr      <= qsim_pkg::state_addr_t'(1);
      gate_rd_addr    <= '0;
      scratch_base    <= '0;
      scratch_rd_addr <= '0;
    end else if (mem_cmd.load_header) begin
      in_rd_addr <= '0;
    end else begin
      if (mem_cmd.fetch_next) begin
        gate_rd_addr <= gate_rd_addr + 1'b1;
      end
      // Restart wins over the element advance at row end
      if (mem_cmd.row_restart) begin
        if (from_scratch) begin
          scratch_rd_addr <= scratch_base;
        end else begin
          in_rd_addr <= qsim_pkg::state_addr_t'(1);
        end
      end else if (mem_cmd.fetch_next) begin
        if (from_scratch) begin
          scratch_rd_addr <= scratch_rd_addr + 1'b1;
        end else begin
          in_rd_addr <= in_rd_addr + 1'b1;
        end
      end
      // Next gate reads the vector just written
      if (mem_cmd.gate_done) begin
        scratch_base    <= scratch_wr_base;
        scratch_rd_addr <= scratch_wr_base;
      end
    end
  end

  // --------------------
  // Write side
  // --------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      scratch_wr_base <= '0;
      scratch_wr_addr <= '0;
      out_wr_addr     <= '0;
      out_wr          <= '0;
      scratch_wr      <= '0;
    end else begin
      out_wr.en     <= mem_cmd.store_out;
      scratch_wr.en <= mem_cmd.store_scratch;
      if (mem_cmd.clear) begin
        scratch_wr_base <= '0;
        scratch_wr_addr <= '0;
        out_wr_addr     <= '0;
      end
      if (mem_cmd.store_out) begin
        out_wr.addr <= out_wr_addr;
        out_wr.data <= acc;
        out_wr_addr <= out_wr_addr + 1'b1;
      end
      if (mem_cmd.store_scratch) begin
        scratch_wr.addr <= scratch_wr_addr;
        scratch_wr.data <= acc;
        scratch_wr_addr <= scratch_wr_addr + 1'b1;
      end
      if (mem_cmd.gate_done) begin
        scratch_wr_base <= scratch_wr_addr;
      end
    end
  end

endmodule

/* verilog/qsim_pkg.sv */
package qsim_pkg;

  // --------------------
  // Sizes
  // --------------------
  localparam int HALF_W       = 32;
  localparam int FRAC_BITS    = 16;
  localparam int MAX_QUBITS   = 4;
  localparam int MAX_GATES    = 31;
  localparam int STATE_ADDR_W = 5;
  localparam int GATE_ADDR_W  = 13;

  // Widths of the qubit and gate count fields taken from the header
  localparam int QCNT_W = $clog2(MAX_QUBITS + 1);
  localparam int GCNT_W = $clog2(MAX_GATES + 1);

  // --------------------
  // Words and addresses
  // --------------------
  typedef logic [STATE_ADDR_W-1:0] state_addr_t;
  typedef logic [GATE_ADDR_W-1:0]  gate_addr_t;

  // One SRAM word, real part in the upper half
  typedef struct packed {
    logic signed [HALF_W-1:0] re;
    logic signed [HALF_W-1:0] im;
  } cplx_t;

  // Output SRAM write port
  typedef struct packed {
    logic        en;
    state_addr_t addr;
    cplx_t       data;
  } state_wr_t;

  // Scratchpad write port
  typedef struct packed {
    logic       en;
    gate_addr_t addr;
    cplx_t      data;
  } scratch_wr_t;

  // --------------------
  // Control commands
  // --------------------
  typedef struct packed {
    logic load_header;
    logic fetch_next;
    logic row_restart;
    logic gate_done;
    logic store_out;
    logic store_scratch;
    logic clear;
  } mem_cmd_t;

  typedef enum logic [2:0] {
    MAC_IDLE,
    MAC_CLEAR,
    MAC_RR,
    MAC_II,
    MAC_RI,
    MAC_IR
  } mac_op_t;

endpackage

/* verilog/qsim_top.sv */
`timescale 1ns/1ps

module qsim_top (
  input  logic                  clk,
  input  logic                  reset_n,

  // Run control
  input  logic                  dut_valid,
  output logic                  dut_ready,

  // Input state SRAM
  output qsim_pkg::state_addr_t q_state_input_sram_read_address,
  input  qsim_pkg::cplx_t       q_state_input_sram_read_data,

  // Gate SRAM
  output qsim_pkg::gate_addr_t  q_gates_sram_read_address,
  input  qsim_pkg::cplx_t       q_gates_sram_read_data,

  // Scratchpad SRAM
  output qsim_pkg::gate_addr_t  scratchpad_sram_read_address,
  input  qsim_pkg::cplx_t       scratchpad_sram_read_data,

  // Write ports
  output qsim_pkg::state_wr_t   q_state_output_sram_wr,
  output qsim_pkg::scratch_wr_t scratchpad_sram_wr
);

  qsim_pkg::mem_cmd_t mem_cmd;
  qsim_pkg::mac_op_t  mac_op;
  qsim_pkg::cplx_t    acc;
  logic               from_scratch;

  // --------------------
  // Run sequencing
  // --------------------
  qsim_ctrl ctrl_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .dut_valid    (dut_valid),
    .header       (q_state_input_sram_read_data),
    .dut_ready    (dut_ready),
    .mem_cmd      (mem_cmd),
    .mac_op       (mac_op),
    .from_scratch (from_scratch)
  );

  // --------------------
  // Address and write port generation
  // --------------------
  qsim_mem_seq mem_seq_i (
    .clk             (clk),
    .reset_n         (reset_n),
    .mem_cmd         (mem_cmd),
    .from_scratch    (from_scratch),
    .acc             (acc),
    .in_rd_addr      (q_state_input_sram_read_address),
    .gate_rd_addr    (q_gates_sram_read_address),
    .scratch_rd_addr (scratchpad_sram_read_address),
    .out_wr          (q_state_output_sram_wr),
    .scratch_wr      (scratchpad_sram_wr)
  );

  // --------------------
  // Arithmetic
  // --------------------
  qsim_cmac cmac_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .mac_op       (mac_op),
    .from_scratch (from_scratch),
    .gate_data    (q_gates_sram_read_data),
    .state_data   (q_state_input_sram_read_data),
    .scratch_data (scratchpad_sram_read_data),
    .acc          (acc)
  );

endmodule
